// File: verilog/fir_data_pkg.sv
package fir_data_pkg;

    localparam int NUM_TAPS   = 24;
    localparam int SAMPLE_W   = 16;
    localparam int COEFF_W    = 16;
    localparam int PROD_W     = SAMPLE_W + COEFF_W;
    // five guard bits cover the sum of 24 full-scale products.
    localparam int ACC_W      = PROD_W + 5;
    localparam int SHIFT_W    = 5;
    localparam int GROUP_SIZE = 6;
    localparam int NUM_GROUPS = NUM_TAPS / GROUP_SIZE;

    // q15 coefficients.
    localparam logic [SHIFT_W-1:0] DEFAULT_SHIFT = 5'd15;

    typedef logic signed [SAMPLE_W-1:0] sample_t;
    typedef logic signed [COEFF_W-1:0]  coeff_t;
    typedef logic signed [PROD_W-1:0]   prod_t;
    typedef logic signed [ACC_W-1:0]    acc_t;

    // element 0 is the newest sample.
    typedef sample_t [NUM_TAPS-1:0] tap_vec_t;
    typedef coeff_t  [NUM_TAPS-1:0] coeff_vec_t;

    // output clamp limits.
    localparam sample_t SAMPLE_MAX = 16'sh7fff;
    localparam sample_t SAMPLE_MIN = 16'sh8000;

endpackage

// File: verilog/fir_cfg_pkg.sv
package fir_cfg_pkg;

    typedef enum logic {
        CFG_WRITE = 1'b0,
        CFG_READ  = 1'b1
    } cfg_op_t;

    localparam int CFG_ADDR_W = 5;

    // addresses 0 to 23 hold c0 to c23.
    localparam logic [CFG_ADDR_W-1:0] SHIFT_ADDR = 5'd24;

    // one past the last mapped address.
    localparam int NUM_REGS = 25;

endpackage

// File: verilog/fir_input_pipeline.sv
`timescale 1ns/1ps

module fir_input_pipeline
    import fir_data_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     shift_en,
    input  sample_t  in_sample,
    output tap_vec_t taps
);

    tap_vec_t taps_q;

    // moves only on an accepted sample.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            taps_q <= '0;
        end else if (shift_en) begin
            for (int k = NUM_TAPS - 1; k > 0; k--) begin
                taps_q[k] <= taps_q[k-1];
            end
            taps_q[0] <= in_sample;
        end
    end

    assign taps = taps_q;

endmodule

// File: verilog/fir_coeff_regs.sv
`timescale 1ns/1ps

module fir_coeff_regs
    import fir_cfg_pkg::*;
    import fir_data_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  cfg_valid,
    output logic                  cfg_ready,
    input  cfg_op_t               cfg_op,
    input  logic [CFG_ADDR_W-1:0] cfg_addr,
    input  logic [COEFF_W-1:0]    cfg_wdata,
    output logic                  rsp_valid,
    input  logic                  rsp_ready,
    output logic [COEFF_W-1:0]    rsp_data,
    output coeff_vec_t            coeffs,
    output logic [SHIFT_W-1:0]    out_shift
);

    logic               cmd_accept;
    logic               do_write;
    logic               do_read;
    logic               addr_valid;
    logic               is_coeff;
    logic [COEFF_W-1:0] rd_value;

    // no new command while a response waits.
    assign cfg_ready  = !rsp_valid;
    assign cmd_accept = cfg_valid && cfg_ready;
    assign do_write   = cmd_accept && (cfg_op == CFG_WRITE);
    assign do_read    = cmd_accept && (cfg_op == CFG_READ);

    assign addr_valid = cfg_addr < CFG_ADDR_W'(NUM_REGS);
    assign is_coeff   = cfg_addr < CFG_ADDR_W'(NUM_TAPS);

    always_comb begin
        rd_value = '0;
        if (is_coeff) begin
            rd_value = coeffs[cfg_addr];
        end else if (cfg_addr == SHIFT_ADDR) begin
            rd_value = {{(COEFF_W - SHIFT_W){1'b0}}, out_shift};
        end
    end

    // the only mapped address above the coefficients is the shift.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            coeffs    <= '0;
            out_shift <= DEFAULT_SHIFT;
        end else if (do_write && addr_valid) begin
            if (is_coeff) begin
                coeffs[cfg_addr] <= cfg_wdata;
            end else begin
                out_shift <= cfg_wdata[SHIFT_W-1:0];
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rsp_valid <= 1'b0;
        end else if (do_read) begin
            rsp_valid <= 1'b1;
        end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (do_read) begin
            rsp_data <= rd_value;
        end
    end

    // held response keeps its data until taken.
    assert property (@(posedge clk) disable iff (reset)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_data))
        else $error("read response changed while stalled");

endmodule

// File: verilog/fir_mac.sv
`timescale 1ns/1ps

module fir_mac
    import fir_data_pkg::*;
(
    input  logic               clk,
    input  logic               reset,
    input  logic               advance,
    input  logic               sample_valid,
    input  tap_vec_t           taps,
    input  coeff_vec_t         coeffs,
    input  logic [SHIFT_W-1:0] out_shift,
    output logic               out_valid,
    output sample_t            out_data
);

    // taps_valid marks a fresh sample sitting in the delay line.
    logic taps_valid;
    logic prod_valid;
    logic part_valid;

    prod_t [NUM_TAPS-1:0]   prod_q;
    acc_t  [NUM_GROUPS-1:0] part_d;
    acc_t  [NUM_GROUPS-1:0] part_q;
    acc_t                   total;
    acc_t                   scaled;
    sample_t                clamped;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            taps_valid <= 1'b0;
            prod_valid <= 1'b0;
            part_valid <= 1'b0;
            out_valid  <= 1'b0;
        end else if (advance) begin
            taps_valid <= sample_valid;
            prod_valid <= taps_valid;
            part_valid <= prod_valid;
            out_valid  <= part_valid;
        end
    end

    // stage 1.
    always_ff @(posedge clk) begin
        if (advance) begin
            for (int k = 0; k < NUM_TAPS; k++) begin
                prod_q[k] <= taps[k] * coeffs[k];
            end
        end
    end

    always_comb begin
        for (int g = 0; g < NUM_GROUPS; g++) begin
            part_d[g] = '0;
            for (int k = 0; k < GROUP_SIZE; k++) begin
                part_d[g] = part_d[g] + acc_t'(prod_q[g*GROUP_SIZE + k]);
            end
        end
    end

    // stage 2.
    always_ff @(posedge clk) begin
        if (advance) begin
            part_q <= part_d;
        end
    end

    // arithmetic shift floors toward minus infinity.
    always_comb begin
        total = '0;
        for (int g = 0; g < NUM_GROUPS; g++) begin
            total = total + part_q[g];
        end
        scaled = total >>> out_shift;
        if (scaled > acc_t'(SAMPLE_MAX)) begin
            clamped = SAMPLE_MAX;
        end else if (scaled < acc_t'(SAMPLE_MIN)) begin
            clamped = SAMPLE_MIN;
        end else begin
            clamped = scaled[SAMPLE_W-1:0];
        end
    end

    // stage 3.
    always_ff @(posedge clk) begin
        if (advance) begin
            out_data <= clamped;
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        out_valid && !advance |=> out_valid && $stable(out_data))
        else $error("output changed under back-pressure");

endmodule

// File: verilog/fir_filter.sv
`timescale 1ns/1ps

module fir_filter
    import fir_data_pkg::*;
    import fir_cfg_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  sample_t               in_data,
    output logic                  out_valid,
    input  logic                  out_ready,
    output sample_t               out_data,
    input  logic                  cfg_valid,
    output logic                  cfg_ready,
    input  cfg_op_t               cfg_op,
    input  logic [CFG_ADDR_W-1:0] cfg_addr,
    input  logic [COEFF_W-1:0]    cfg_wdata,
    output logic                  rsp_valid,
    input  logic                  rsp_ready,
    output logic [COEFF_W-1:0]    rsp_data
);

    logic               advance;
    logic               accept;
    tap_vec_t           taps;
    coeff_vec_t         coeffs;
    logic [SHIFT_W-1:0] out_shift;

    // whole pipeline moves when the output register can drain.
    assign advance  = !out_valid || out_ready;
    assign in_ready = advance;
    assign accept   = in_valid && advance;

    fir_input_pipeline fir_input_pipeline_i (
        .clk       (clk),
        .reset     (reset),
        .shift_en  (accept),
        .in_sample (in_data),
        .taps      (taps)
    );

    fir_coeff_regs fir_coeff_regs_i (
        .clk       (clk),
        .reset     (reset),
        .cfg_valid (cfg_valid),
        .cfg_ready (cfg_ready),
        .cfg_op    (cfg_op),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp_data  (rsp_data),
        .coeffs    (coeffs),
        .out_shift (out_shift)
    );

    fir_mac fir_mac_i (
        .clk          (clk),
        .reset        (reset),
        .advance      (advance),
        .sample_valid (accept),
        .taps         (taps),
        .coeffs       (coeffs),
        .out_shift    (out_shift),
        .out_valid    (out_valid),
        .out_data     (out_data)
    );

endmodule

// File: tests/fir_filter_tb.sv
`timescale 1ns/1ps

module fir_filter_tb
    import fir_data_pkg::*;
    import fir_cfg_pkg::*;
();

    localparam int TIMEOUT = 2000;

    logic                  clk;
    logic                  reset;
    logic                  in_valid;
    logic                  in_ready;
    sample_t               in_data;
    logic                  out_valid;
    logic                  out_ready;
    sample_t               out_data;
    logic                  cfg_valid;
    logic                  cfg_ready;
    cfg_op_t               cfg_op;
    logic [CFG_ADDR_W-1:0] cfg_addr;
    logic [COEFF_W-1:0]    cfg_wdata;
    logic                  rsp_valid;
    logic                  rsp_ready;
    logic [COEFF_W-1:0]    rsp_data;

    int          value_errors;
    int          other_failures;
    int          expected_q[$];
    int          seen_q[$];
    int          history[NUM_TAPS];
    int          coef_model[NUM_TAPS];
    int          shift_model;
    logic        held_pending;
    int          held_data;
    logic        random_ready;
    logic [10:0] ready_idx;
    bit          ready_pattern[2048];

    fir_filter fir_filter_i (.*);

    always #10 clk = ~clk;

    task automatic check_value(input string name, input int actual, input int expected);
        if (actual != expected) begin
            value_errors++;
            $display("error at %0t: %s is %0d, expected %0d", $time, name, actual, expected);
        end
    endtask

    task automatic report_failure(input string what);
        other_failures++;
        $display("failure at %0t: %s", $time, what);
    endtask

    // floor of the scaled dot product, clamped to 16 bits.
    task automatic record_sample(input int value);
        longint acc;
        acc = 0;
        for (int k = NUM_TAPS - 1; k > 0; k--) begin
            history[k] = history[k-1];
        end
        history[0] = value;
        for (int k = 0; k < NUM_TAPS; k++) begin
            acc = acc + longint'(coef_model[k]) * longint'(history[k]);
        end
        acc = acc >>> shift_model;
        if (acc > 32767) begin
            acc = 32767;
        end else if (acc < -32768) begin
            acc = -32768;
        end
        expected_q.push_back(int'(acc));
    endtask

    task automatic send_sample(input int value);
        int   waited;
        logic accepted;
        waited = 0;
        accepted = 1'b0;
        in_valid = 1'b1;
        in_data = sample_t'(value);
        while (!accepted && waited < TIMEOUT) begin
            @(posedge clk);
            accepted = in_ready;
            waited++;
        end
        if (accepted) begin
            record_sample(value);
        end else begin
            report_failure("input sample was never accepted");
        end
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic issue_command(input cfg_op_t op, input int addr, input int data,
                                 output logic accepted);
        int waited;
        waited = 0;
        accepted = 1'b0;
        cfg_valid = 1'b1;
        cfg_op = op;
        cfg_addr = CFG_ADDR_W'(addr);
        cfg_wdata = COEFF_W'(data);
        while (!accepted && waited < TIMEOUT) begin
            @(posedge clk);
            accepted = cfg_ready;
            waited++;
        end
        @(negedge clk);
        cfg_valid = 1'b0;
        if (!accepted) begin
            report_failure("command was never accepted");
        end
    endtask

    task automatic write_reg(input int addr, input int data);
        logic accepted;
        issue_command(CFG_WRITE, addr, data, accepted);
        if (accepted && addr < NUM_TAPS) begin
            coef_model[addr] = int'(coeff_t'(data));
        end else if (accepted && addr == int'(SHIFT_ADDR)) begin
            shift_model = data & 31;
        end
    endtask

    task automatic read_reg(input int addr, output int data);
        int   waited;
        logic accepted;
        logic got;
        waited = 0;
        got = 1'b0;
        data = 0;
        issue_command(CFG_READ, addr, 0, accepted);
        while (accepted && !got && waited < TIMEOUT) begin
            @(posedge clk);
            got = rsp_valid && rsp_ready;
            data = int'(rsp_data);
            waited++;
        end
        if (got) begin
            check_value("rsp_valid delay", waited, 1);
        end else begin
            report_failure("read response never arrived");
        end
        @(negedge clk);
    endtask

    task automatic wait_for_outputs();
        int waited;
        waited = 0;
        while (expected_q.size() != 0 && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (expected_q.size() != 0) begin
            report_failure("outputs missing after the stream ended");
            expected_q.delete();
        end
    endtask

    task automatic load_random_coeffs(input int range, input int shift);
        for (int k = 0; k < NUM_TAPS; k++) begin
            write_reg(k, int'($urandom_range(0, 2 * range - 1)) - range);
        end
        write_reg(int'(SHIFT_ADDR), shift);
    endtask

    task automatic check_register_access();
        int value;
        int written[NUM_REGS];
        for (int a = 0; a < NUM_TAPS; a++) begin
            read_reg(a, value);
            check_value("rsp_data", value, 0);
        end
        read_reg(int'(SHIFT_ADDR), value);
        check_value("rsp_data", value, 15);
        for (int a = 0; a < NUM_REGS; a++) begin
            written[a] = (a == int'(SHIFT_ADDR)) ? int'($urandom_range(0, 31))
                                                 : int'($urandom_range(0, 65535));
            write_reg(a, written[a]);
        end
        // unmapped address, must leave every register alone.
        write_reg(30, written[int'(SHIFT_ADDR)] ^ 'h1f);
        for (int a = 0; a < NUM_REGS; a++) begin
            read_reg(a, value);
            check_value("rsp_data", value, written[a]);
        end
        read_reg(30, value);
        check_value("rsp_data", value, 0);
    endtask

    task automatic check_impulse_response();
        load_random_coeffs(32768, 0);
        repeat (NUM_TAPS) send_sample(0);
        wait_for_outputs();
        seen_q.delete();
        send_sample(1);
        repeat (NUM_TAPS - 1) send_sample(0);
        wait_for_outputs();
        if (seen_q.size() != NUM_TAPS) begin
            report_failure("impulse response has the wrong number of outputs");
        end else begin
            for (int k = 0; k < NUM_TAPS; k++) begin
                check_value("out_data", seen_q[k], coef_model[k]);
            end
        end
    endtask

    task automatic run_full_rate_stream();
        int lat;
        load_random_coeffs(4096, 15);
        send_sample(int'($urandom_range(0, 65535)) - 32768);
        lat = 0;
        while (!out_valid && lat < TIMEOUT) begin
            @(negedge clk);
            lat++;
        end
        check_value("out_valid delay", lat, 3);
        repeat (99) send_sample(int'($urandom_range(0, 65535)) - 32768);
        wait_for_outputs();
    endtask

    task automatic check_saturation();
        for (int k = 0; k < NUM_TAPS; k++) begin
            write_reg(k, 32767);
        end
        write_reg(int'(SHIFT_ADDR), 0);
        seen_q.delete();
        repeat (NUM_TAPS) send_sample(32767);
        repeat (NUM_TAPS) send_sample(-32767);
        wait_for_outputs();
        if (seen_q.size() != 2 * NUM_TAPS) begin
            report_failure("saturation run has the wrong number of outputs");
        end else begin
            check_value("out_data", seen_q[NUM_TAPS-1], 32767);
            check_value("out_data", seen_q[2*NUM_TAPS-1], -32768);
        end
    endtask

    task automatic run_with_backpressure();
        for (int i = 0; i < 2048; i++) begin
            ready_pattern[i] = 1'($urandom_range(0, 1));
        end
        load_random_coeffs(4096, 15);
        @(posedge clk);
        random_ready = 1'b1;
        @(negedge clk);
        repeat (150) begin
            send_sample(int'($urandom_range(0, 65535)) - 32768);
            repeat ($urandom_range(0, 3)) @(negedge clk);
        end
        wait_for_outputs();
        @(posedge clk);
        random_ready = 1'b0;
        @(negedge clk);
    endtask

    task automatic check_held_response();
        logic accepted;
        int   held;
        rsp_ready = 1'b0;
        issue_command(CFG_READ, 5, 0, accepted);
        held = coef_model[5] & 'hffff;
        repeat (4) begin
            check_value("rsp_valid", int'(rsp_valid), 1);
            check_value("cfg_ready", int'(cfg_ready), 0);
            check_value("rsp_data", int'(rsp_data), held);
            @(negedge clk);
        end
        rsp_ready = 1'b1;
        @(posedge clk);
        check_value("rsp_valid", int'(rsp_valid), 1);
        check_value("rsp_data", int'(rsp_data), held);
        @(negedge clk);
        check_value("cfg_ready", int'(cfg_ready), 1);
    endtask

    always @(negedge clk) begin
        if (random_ready) begin
            out_ready = ready_pattern[ready_idx];
            ready_idx = ready_idx + 1'b1;
        end else begin
            out_ready = 1'b1;
        end
    end

    // in-order output check, and a stalled output must hold.
    always @(posedge clk) begin
        if (reset) begin
            held_pending = 1'b0;
        end else begin
            if (held_pending) begin
                check_value("out_valid", int'(out_valid), 1);
                check_value("out_data", int'(out_data), held_data);
            end
            if (out_valid && out_ready) begin
                seen_q.push_back(int'(out_data));
                if (expected_q.size() == 0) begin
                    report_failure("output arrived with no sample pending");
                end else begin
                    check_value("out_data", int'(out_data), expected_q.pop_front());
                end
            end
            held_pending = out_valid && !out_ready;
            held_data = int'(out_data);
        end
    end

    initial begin
        void'($urandom(29421));
        clk = 1'b0;
        reset = 1'b1;
        in_valid = 1'b0;
        in_data = '0;
        out_ready = 1'b1;
        cfg_valid = 1'b0;
        cfg_op = CFG_WRITE;
        cfg_addr = '0;
        cfg_wdata = '0;
        rsp_ready = 1'b1;
        value_errors = 0;
        other_failures = 0;
        held_pending = 1'b0;
        held_data = 0;
        random_ready = 1'b0;
        ready_idx = '0;
        shift_model = 15;
        for (int k = 0; k < NUM_TAPS; k++) begin
            history[k] = 0;
            coef_model[k] = 0;
        end
        repeat (10) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        check_value("in_ready", int'(in_ready), 1);
        check_value("cfg_ready", int'(cfg_ready), 1);
        check_value("out_valid", int'(out_valid), 0);
        check_value("rsp_valid", int'(rsp_valid), 0);
        check_register_access();
        check_impulse_response();
        run_full_rate_stream();
        check_saturation();
        run_with_backpressure();
        check_held_response();
        $display("%0d value errors, %0d other failures", value_errors, other_failures);
        if (value_errors == 0 && other_failures == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: fir_filter.f
verilog/fir_data_pkg.sv
verilog/fir_cfg_pkg.sv
verilog/fir_input_pipeline.sv
verilog/fir_coeff_regs.sv
verilog/fir_mac.sv
verilog/fir_filter.sv
tests/fir_filter_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the FIR testbench with Verilator and run it.
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
        --top-module fir_filter_tb -f fir_filter.f \
        --Mdir obj_dir -o fir_filter_sim; then
    echo "compile failed"
    exit 1
fi

sim_output=$(./obj_dir/fir_filter_sim)
sim_status=$?
printf '%s\n' "$sim_output"

if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_output" | grep -qx "All checks passed"; then
    exit 0
fi

echo "pass message not found in simulation output"
exit 1
